// ==== hw/core_settings.svh ====
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// data and address width
`define CORE_XLEN 32

// architectural registers and index width
`define CORE_REG_COUNT 32
`define CORE_REG_AW $clog2(`CORE_REG_COUNT)

`define CORE_RESET_PC 32'h0000_0000

// addi x0, x0, 0
`define CORE_NOP 32'h0000_0013

`endif

// ==== hw/core_pkg.sv ====
`default_nettype none

`include "core_settings.svh"

package core_pkg;

  // major opcodes of the supported subset
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND
  } alu_op_e;

  // non-memory result source
  typedef enum logic [1:0] {
    RES_ALU,
    RES_PC4,
    RES_IMM
  } res_sel_e;

  // EX operand source
  typedef enum logic [1:0] {
    FWD_REG,
    FWD_MEM,
    FWD_WB
  } fwd_sel_e;

  // ==========================================================================
  // stage registers
  // ==========================================================================

  typedef struct packed {
    logic     reg_write;
    logic     mem_read;
    logic     mem_write;
    logic     branch;
    logic     jump;
    logic     jalr;
    logic     alu_src_imm;
    logic     pc_as_op1;
    res_sel_e res_sel;
    alu_op_e  alu_op;
  } ctrl_t;

  typedef struct packed {
    logic [`CORE_XLEN-1:0] pc;
    logic [`CORE_XLEN-1:0] pc_plus_4;
    logic [`CORE_XLEN-1:0] inst;
  } if_id_t;

  typedef struct packed {
    logic [`CORE_XLEN-1:0]   pc;
    logic [`CORE_XLEN-1:0]   pc_plus_4;
    logic [`CORE_REG_AW-1:0] rs1;
    logic [`CORE_REG_AW-1:0] rs2;
    logic [`CORE_REG_AW-1:0] rd;
    logic [2:0]              fun3;
    logic [`CORE_XLEN-1:0]   rdata1;
    logic [`CORE_XLEN-1:0]   rdata2;
    logic [`CORE_XLEN-1:0]   imm;
    ctrl_t                   ctrl;
  } id_ex_t;

  typedef struct packed {
    logic [`CORE_XLEN-1:0]   pc_plus_4;
    logic [`CORE_XLEN-1:0]   jump_target;
    logic                    taken;
    logic [`CORE_REG_AW-1:0] rd;
    logic [`CORE_XLEN-1:0]   alu_result;
    logic [`CORE_XLEN-1:0]   store_data;
    logic [`CORE_XLEN-1:0]   imm;
    ctrl_t                   ctrl;
  } ex_mem_t;

  typedef struct packed {
    logic [`CORE_REG_AW-1:0] rd;
    logic [`CORE_XLEN-1:0]   result;
    logic [`CORE_XLEN-1:0]   load_data;
    logic                    reg_write;
    logic                    mem_read;
  } mem_wb_t;

endpackage

`default_nettype wire

// ==== hw/fetch_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "core_settings.svh"

module fetch_stage (
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  logic                  stall_i,
  input  logic                  flush_i,
  input  logic                  redirect_i,
  input  logic [`CORE_XLEN-1:0] redirect_pc_i,
  input  logic [`CORE_XLEN-1:0] imem_rdata_i,
  output logic [`CORE_XLEN-1:0] imem_addr_o,
  output core_pkg::if_id_t      if_id_o
);

  logic [`CORE_XLEN-1:0] pc;
  logic [`CORE_XLEN-1:0] pc_plus_4;
  logic [`CORE_XLEN-1:0] pc_next;

  assign pc_plus_4   = pc + `CORE_XLEN'(4);
  assign imem_addr_o = pc;

  // redirect wins over a pending stall
  assign pc_next = redirect_i ? redirect_pc_i : (stall_i ? pc : pc_plus_4);

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pc <= `CORE_RESET_PC;
    end else begin
      pc <= pc_next;
    end
  end

  // IF/ID, a flushed slot holds a nop
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      if_id_o <= '{pc: '0, pc_plus_4: '0, inst: `CORE_NOP};
    end else if (flush_i) begin
      if_id_o <= '{pc: '0, pc_plus_4: '0, inst: `CORE_NOP};
    end else if (!stall_i) begin
      if_id_o <= '{pc: pc, pc_plus_4: pc_plus_4, inst: imem_rdata_i};
    end
  end

endmodule

`default_nettype wire

// ==== hw/decode_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "core_settings.svh"

module decode_stage (
  input  logic                    clk,
  input  logic                    rst_n_i,
  input  logic                    stall_i,
  input  logic                    flush_i,
  input  core_pkg::if_id_t        if_id_i,
  input  logic [`CORE_XLEN-1:0]   rdata1_i,
  input  logic [`CORE_XLEN-1:0]   rdata2_i,
  input  logic                    wb_we_i,
  input  logic [`CORE_REG_AW-1:0] wb_rd_i,
  input  logic [`CORE_XLEN-1:0]   wb_data_i,
  output logic [`CORE_REG_AW-1:0] rs1_o,
  output logic [`CORE_REG_AW-1:0] rs2_o,
  output core_pkg::id_ex_t        id_ex_o
);

  import core_pkg::*;

  logic [`CORE_XLEN-1:0]   inst;
  opcode_e                 opcode;
  logic [2:0]              fun3;
  logic [6:0]              fun7;
  ctrl_t                   ctrl;
  logic                    use_rs1;
  logic                    use_rs2;
  logic [`CORE_XLEN-1:0]   imm;
  logic [`CORE_XLEN-1:0]   rdata1;
  logic [`CORE_XLEN-1:0]   rdata2;
  id_ex_t                  id_ex_d;

  assign inst   = if_id_i.inst;
  assign opcode = opcode_e'(inst[6:0]);
  assign fun3   = inst[14:12];
  assign fun7   = inst[31:25];

  // alt selects sub / sra, sub only exists for register operands
  function automatic alu_op_e alu_decode(input logic [2:0] f3, input logic alt,
                                         input logic is_reg);
    alu_op_e op;
    case (f3)
      3'b000:  op = (alt && is_reg) ? ALU_SUB : ALU_ADD;
      3'b001:  op = ALU_SLL;
      3'b010:  op = ALU_SLT;
      3'b011:  op = ALU_SLTU;
      3'b100:  op = ALU_XOR;
      3'b101:  op = alt ? ALU_SRA : ALU_SRL;
      3'b110:  op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  // ==========================================================================
  // control and immediate
  // ==========================================================================

  always_comb begin
    ctrl    = '0;
    use_rs1 = 1'b0;
    use_rs2 = 1'b0;
    imm     = '0;
    case (opcode)
      OPC_OP: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_op    = alu_decode(fun3, fun7[5], 1'b1);
        use_rs1        = 1'b1;
        use_rs2        = 1'b1;
      end
      OPC_OP_IMM: begin
        ctrl.reg_write   = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        ctrl.alu_op      = alu_decode(fun3, fun7[5], 1'b0);
        use_rs1          = 1'b1;
        imm              = {{(`CORE_XLEN-12){inst[31]}}, inst[31:20]};
      end
      OPC_LUI: begin
        ctrl.reg_write = 1'b1;
        ctrl.res_sel   = RES_IMM;
        imm            = {inst[31:12], 12'b0};
      end
      OPC_AUIPC: begin
        ctrl.reg_write   = 1'b1;
        ctrl.pc_as_op1   = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        imm              = {inst[31:12], 12'b0};
      end
      OPC_LOAD: begin
        ctrl.reg_write   = 1'b1;
        ctrl.mem_read    = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        use_rs1          = 1'b1;
        imm              = {{(`CORE_XLEN-12){inst[31]}}, inst[31:20]};
      end
      OPC_STORE: begin
        ctrl.mem_write   = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        use_rs1          = 1'b1;
        use_rs2          = 1'b1;
        imm              = {{(`CORE_XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
      end
      OPC_BRANCH: begin
        ctrl.branch = 1'b1;
        use_rs1     = 1'b1;
        use_rs2     = 1'b1;
        imm         = {{(`CORE_XLEN-12){inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
      end
      OPC_JAL: begin
        ctrl.reg_write = 1'b1;
        ctrl.jump      = 1'b1;
        ctrl.res_sel   = RES_PC4;
        imm = {{(`CORE_XLEN-20){inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
      end
      OPC_JALR: begin
        ctrl.reg_write = 1'b1;
        ctrl.jump      = 1'b1;
        ctrl.jalr      = 1'b1;
        ctrl.res_sel   = RES_PC4;
        use_rs1        = 1'b1;
        imm            = {{(`CORE_XLEN-12){inst[31]}}, inst[31:20]};
      end
      default: begin
        ctrl = '0;
      end
    endcase
  end

  // unused source fields read as x0 so they never match a hazard
  assign rs1_o = use_rs1 ? inst[19:15] : '0;
  assign rs2_o = use_rs2 ? inst[24:20] : '0;

  // same-cycle write-back bypass
  assign rdata1 = (wb_we_i && wb_rd_i != '0 && wb_rd_i == rs1_o) ? wb_data_i : rdata1_i;
  assign rdata2 = (wb_we_i && wb_rd_i != '0 && wb_rd_i == rs2_o) ? wb_data_i : rdata2_i;

  assign id_ex_d = '{
    pc:        if_id_i.pc,
    pc_plus_4: if_id_i.pc_plus_4,
    rs1:       rs1_o,
    rs2:       rs2_o,
    rd:        inst[11:7],
    fun3:      fun3,
    rdata1:    rdata1,
    rdata2:    rdata2,
    imm:       imm,
    ctrl:      (stall_i || flush_i) ? '0 : ctrl
  };

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      id_ex_o <= '0;
    end else begin
      id_ex_o <= id_ex_d;
    end
  end

endmodule

`default_nettype wire

// ==== hw/reg_file.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "core_settings.svh"

module reg_file (
  input  logic                    clk,
  input  logic                    rst_n_i,
  input  logic [`CORE_REG_AW-1:0] raddr1_i,
  input  logic [`CORE_REG_AW-1:0] raddr2_i,
  input  logic                    we_i,
  input  logic [`CORE_REG_AW-1:0] waddr_i,
  input  logic [`CORE_XLEN-1:0]   wdata_i,
  output logic [`CORE_XLEN-1:0]   rdata1_o,
  output logic [`CORE_XLEN-1:0]   rdata2_o
);

  logic [`CORE_XLEN-1:0] regs [`CORE_REG_COUNT];

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < `CORE_REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && waddr_i != '0) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  // x0 hardwired
  assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
  assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

`default_nettype wire

// ==== hw/execute_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "core_settings.svh"

module execute_stage (
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  logic                  flush_i,
  input  core_pkg::id_ex_t      id_ex_i,
  input  core_pkg::fwd_sel_e    fwd1_i,
  input  core_pkg::fwd_sel_e    fwd2_i,
  input  logic [`CORE_XLEN-1:0] mem_result_i,
  input  logic [`CORE_XLEN-1:0] wb_data_i,
  output core_pkg::ex_mem_t     ex_mem_o
);

  import core_pkg::*;

  logic [`CORE_XLEN-1:0]         op_a;
  logic [`CORE_XLEN-1:0]         op_b;
  logic [`CORE_XLEN-1:0]         alu_a;
  logic [`CORE_XLEN-1:0]         alu_b;
  logic [$clog2(`CORE_XLEN)-1:0] shamt;
  logic [`CORE_XLEN-1:0]         alu_res;
  logic                          cond;
  logic [`CORE_XLEN-1:0]         target_sum;

  function automatic logic [`CORE_XLEN-1:0] fwd_mux(input fwd_sel_e sel,
                                                     input logic [`CORE_XLEN-1:0] reg_val);
    case (sel)
      FWD_MEM: return mem_result_i;
      FWD_WB:  return wb_data_i;
      default: return reg_val;
    endcase
  endfunction

  assign op_a  = fwd_mux(fwd1_i, id_ex_i.rdata1);
  assign op_b  = fwd_mux(fwd2_i, id_ex_i.rdata2);
  assign alu_a = id_ex_i.ctrl.pc_as_op1 ? id_ex_i.pc : op_a;
  assign alu_b = id_ex_i.ctrl.alu_src_imm ? id_ex_i.imm : op_b;
  assign shamt = alu_b[$clog2(`CORE_XLEN)-1:0];

  // ==========================================================================
  // ALU
  // ==========================================================================

  always_comb begin
    case (id_ex_i.ctrl.alu_op)
      ALU_ADD:  alu_res = alu_a + alu_b;
      ALU_SUB:  alu_res = alu_a - alu_b;
      ALU_SLL:  alu_res = alu_a << shamt;
      ALU_SLT:  alu_res = {{(`CORE_XLEN-1){1'b0}}, $signed(alu_a) < $signed(alu_b)};
      ALU_SLTU: alu_res = {{(`CORE_XLEN-1){1'b0}}, alu_a < alu_b};
      ALU_XOR:  alu_res = alu_a ^ alu_b;
      ALU_SRL:  alu_res = alu_a >> shamt;
      ALU_SRA:  alu_res = $unsigned($signed(alu_a) >>> shamt);
      ALU_OR:   alu_res = alu_a | alu_b;
      ALU_AND:  alu_res = alu_a & alu_b;
      default:  alu_res = alu_a + alu_b;
    endcase
  end

  // branch condition on the forwarded register operands
  always_comb begin
    case (id_ex_i.fun3)
      3'b000:  cond = (op_a == op_b);
      3'b001:  cond = (op_a != op_b);
      3'b100:  cond = ($signed(op_a) < $signed(op_b));
      3'b101:  cond = ($signed(op_a) >= $signed(op_b));
      3'b110:  cond = (op_a < op_b);
      3'b111:  cond = (op_a >= op_b);
      default: cond = 1'b0;
    endcase
  end

  // jalr bases on rs1, branches and jal on the pc
  assign target_sum = (id_ex_i.ctrl.jalr ? op_a : id_ex_i.pc) + id_ex_i.imm;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ex_mem_o <= '0;
    end else if (flush_i) begin
      ex_mem_o <= '0;
    end else begin
      ex_mem_o <= '{
        pc_plus_4:   id_ex_i.pc_plus_4,
        jump_target: {target_sum[`CORE_XLEN-1:1], 1'b0},
        taken:       id_ex_i.ctrl.branch & cond,
        rd:          id_ex_i.rd,
        alu_result:  alu_res,
        store_data:  op_b,
        imm:         id_ex_i.imm,
        ctrl:        id_ex_i.ctrl
      };
    end
  end

endmodule

`default_nettype wire

// ==== hw/memory_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "core_settings.svh"

module memory_stage (
  input  logic                    clk,
  input  logic                    rst_n_i,
  input  core_pkg::ex_mem_t       ex_mem_i,
  input  logic [`CORE_XLEN-1:0]   dmem_rdata_i,
  output logic [`CORE_XLEN-1:0]   dmem_addr_o,
  output logic [`CORE_XLEN-1:0]   dmem_wdata_o,
  output logic                    dmem_we_o,
  output logic                    redirect_o,
  output logic [`CORE_XLEN-1:0]   redirect_pc_o,
  output logic [`CORE_XLEN-1:0]   mem_result_o,
  output logic                    wb_we_o,
  output logic [`CORE_REG_AW-1:0] wb_rd_o,
  output logic [`CORE_XLEN-1:0]   wb_data_o
);

  import core_pkg::*;

  mem_wb_t mem_wb;

  assign dmem_addr_o  = ex_mem_i.alu_result;
  assign dmem_wdata_o = ex_mem_i.store_data;
  assign dmem_we_o    = ex_mem_i.ctrl.mem_write;

  // branch or jump resolved here
  assign redirect_o    = ex_mem_i.taken | ex_mem_i.ctrl.jump;
  assign redirect_pc_o = ex_mem_i.jump_target;

  always_comb begin
    case (ex_mem_i.ctrl.res_sel)
      RES_PC4: mem_result_o = ex_mem_i.pc_plus_4;
      RES_IMM: mem_result_o = ex_mem_i.imm;
      default: mem_result_o = ex_mem_i.alu_result;
    endcase
  end

  // MEM/WB, writes to x0 dropped here
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mem_wb <= '0;
    end else begin
      mem_wb <= '{
        rd:        ex_mem_i.rd,
        result:    mem_result_o,
        load_data: dmem_rdata_i,
        reg_write: ex_mem_i.ctrl.reg_write && (ex_mem_i.rd != '0),
        mem_read:  ex_mem_i.ctrl.mem_read
      };
    end
  end

  // write-back mux
  assign wb_we_o   = mem_wb.reg_write;
  assign wb_rd_o   = mem_wb.rd;
  assign wb_data_o = mem_wb.mem_read ? mem_wb.load_data : mem_wb.result;

endmodule

`default_nettype wire

// ==== hw/hazard_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "core_settings.svh"

module hazard_unit (
  input  logic [`CORE_REG_AW-1:0] id_rs1_i,
  input  logic [`CORE_REG_AW-1:0] id_rs2_i,
  input  core_pkg::id_ex_t        id_ex_i,
  input  core_pkg::ex_mem_t       ex_mem_i,
  input  logic                    wb_we_i,
  input  logic [`CORE_REG_AW-1:0] wb_rd_i,
  input  logic                    redirect_i,
  output core_pkg::fwd_sel_e      fwd1_o,
  output core_pkg::fwd_sel_e      fwd2_o,
  output logic                    stall_o,
  output logic                    flush_o
);

  import core_pkg::*;

  logic load_use;

  // the younger producer in MEM takes priority over WB
  function automatic fwd_sel_e fwd_pick(input logic [`CORE_REG_AW-1:0] rs);
    if (rs == '0) begin
      return FWD_REG;
    end else if (ex_mem_i.ctrl.reg_write && ex_mem_i.rd == rs) begin
      return FWD_MEM;
    end else if (wb_we_i && wb_rd_i == rs) begin
      return FWD_WB;
    end
    return FWD_REG;
  endfunction

  assign fwd1_o = fwd_pick(id_ex_i.rs1);
  assign fwd2_o = fwd_pick(id_ex_i.rs2);

  // load in EX feeding the instruction in decode
  assign load_use = id_ex_i.ctrl.mem_read && (id_ex_i.rd != '0) &&
                    ((id_ex_i.rd == id_rs1_i) || (id_ex_i.rd == id_rs2_i));

  // a redirect discards the stalled instruction anyway
  assign flush_o = redirect_i;
  assign stall_o = load_use && !redirect_i;

endmodule

`default_nettype wire

// ==== hw/core_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "core_settings.svh"

module core_top (
  input  logic                    clk,
  input  logic                    rst_n_i,
  // instruction memory
  output logic [`CORE_XLEN-1:0]   imem_addr_o,
  input  logic [`CORE_XLEN-1:0]   imem_rdata_i,
  // data memory
  output logic [`CORE_XLEN-1:0]   dmem_addr_o,
  output logic [`CORE_XLEN-1:0]   dmem_wdata_o,
  output logic                    dmem_we_o,
  input  logic [`CORE_XLEN-1:0]   dmem_rdata_i,
  // write-back trace
  output logic                    wb_valid_o,
  output logic [`CORE_REG_AW-1:0] wb_rd_o,
  output logic [`CORE_XLEN-1:0]   wb_data_o
);

  import core_pkg::*;

  if_id_t                  if_id;
  id_ex_t                  id_ex;
  ex_mem_t                 ex_mem;
  logic [`CORE_REG_AW-1:0] rs1;
  logic [`CORE_REG_AW-1:0] rs2;
  logic [`CORE_XLEN-1:0]   rdata1;
  logic [`CORE_XLEN-1:0]   rdata2;
  logic                    wb_we;
  logic [`CORE_REG_AW-1:0] wb_rd;
  logic [`CORE_XLEN-1:0]   wb_data;
  logic                    redirect;
  logic [`CORE_XLEN-1:0]   redirect_pc;
  logic [`CORE_XLEN-1:0]   mem_result;
  logic                    stall;
  logic                    flush;
  fwd_sel_e                fwd1;
  fwd_sel_e                fwd2;

  fetch_stage fetch_i (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .stall_i      (stall),
    .flush_i      (flush),
    .redirect_i   (redirect),
    .redirect_pc_i(redirect_pc),
    .imem_rdata_i (imem_rdata_i),
    .imem_addr_o  (imem_addr_o),
    .if_id_o      (if_id)
  );

  decode_stage decode_i (
    .clk      (clk),
    .rst_n_i  (rst_n_i),
    .stall_i  (stall),
    .flush_i  (flush),
    .if_id_i  (if_id),
    .rdata1_i (rdata1),
    .rdata2_i (rdata2),
    .wb_we_i  (wb_we),
    .wb_rd_i  (wb_rd),
    .wb_data_i(wb_data),
    .rs1_o    (rs1),
    .rs2_o    (rs2),
    .id_ex_o  (id_ex)
  );

  reg_file reg_file_i (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .raddr1_i(rs1),
    .raddr2_i(rs2),
    .we_i    (wb_we),
    .waddr_i (wb_rd),
    .wdata_i (wb_data),
    .rdata1_o(rdata1),
    .rdata2_o(rdata2)
  );

  execute_stage execute_i (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .flush_i     (flush),
    .id_ex_i     (id_ex),
    .fwd1_i      (fwd1),
    .fwd2_i      (fwd2),
    .mem_result_i(mem_result),
    .wb_data_i   (wb_data),
    .ex_mem_o    (ex_mem)
  );

  memory_stage memory_i (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .ex_mem_i     (ex_mem),
    .dmem_rdata_i (dmem_rdata_i),
    .dmem_addr_o  (dmem_addr_o),
    .dmem_wdata_o (dmem_wdata_o),
    .dmem_we_o    (dmem_we_o),
    .redirect_o   (redirect),
    .redirect_pc_o(redirect_pc),
    .mem_result_o (mem_result),
    .wb_we_o      (wb_we),
    .wb_rd_o      (wb_rd),
    .wb_data_o    (wb_data)
  );

  hazard_unit hazard_i (
    .id_rs1_i  (rs1),
    .id_rs2_i  (rs2),
    .id_ex_i   (id_ex),
    .ex_mem_i  (ex_mem),
    .wb_we_i   (wb_we),
    .wb_rd_i   (wb_rd),
    .redirect_i(redirect),
    .fwd1_o    (fwd1),
    .fwd2_o    (fwd2),
    .stall_o   (stall),
    .flush_o   (flush)
  );

  // trace taps the register-file write port
  assign wb_valid_o = wb_we;
  assign wb_rd_o    = wb_rd;
  assign wb_data_o  = wb_data;

endmodule

`default_nettype wire

// ==== dv/core_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "core_settings.svh"

module core_tb;

  import core_pkg::*;

  localparam int PROG_WORDS = 64;
  localparam int TIMEOUT    = 8 * PROG_WORDS + 40;
  localparam logic [31:0] LOOP_PC   = 32'(4 * (PROG_WORDS - 1));
  localparam logic [31:0] DATA_BASE = 32'h0000_0100;

  logic                    clk;
  logic                    rst_n_i;
  logic [`CORE_XLEN-1:0]   imem_addr;
  logic [`CORE_XLEN-1:0]   imem_rdata;
  logic [`CORE_XLEN-1:0]   dmem_addr;
  logic [`CORE_XLEN-1:0]   dmem_wdata;
  logic                    dmem_we;
  logic [`CORE_XLEN-1:0]   dmem_rdata;
  logic                    wb_valid;
  logic [`CORE_REG_AW-1:0] wb_rd;
  logic [`CORE_XLEN-1:0]   wb_data;

  logic [31:0] irom [PROG_WORDS];
  logic [31:0] dram [16];
  logic [31:0] lfsr;
  int          cycles;
  logic        loop_seen;
  logic        fetch_checked;

  // expected write-back and store streams from the ISA model
  logic [4:0]  exp_rd_q [$];
  logic [31:0] exp_wd_q [$];
  logic [31:0] exp_sa_q [$];
  logic [31:0] exp_sd_q [$];

  core_top dut_i (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .imem_addr_o (imem_addr),
    .imem_rdata_i(imem_rdata),
    .dmem_addr_o (dmem_addr),
    .dmem_wdata_o(dmem_wdata),
    .dmem_we_o   (dmem_we),
    .dmem_rdata_i(dmem_rdata),
    .wb_valid_o  (wb_valid),
    .wb_rd_o     (wb_rd),
    .wb_data_o   (wb_data)
  );

  // combinational memories with a nop outside the program
  assign imem_rdata = (imem_addr < 32'(4 * PROG_WORDS)) ? irom[imem_addr[7:2]] : `CORE_NOP;
  assign dmem_rdata = dram[dmem_addr[5:2]];

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    if (rst_n_i && dmem_we) begin
      dram[dmem_addr[5:2]] <= dmem_wdata;
    end
  end

  // ==========================================================================
  // helpers
  // ==========================================================================

  task automatic abort_run(input string msg);
    $display("%s at %0t", msg, $time);
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
      $display("Verification failed");
      $fatal(1);
    end
  endtask

  // fibonacci lfsr on taps 32 22 2 1
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int k = 0; k < n; k++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v    = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic logic [31:0] fill_word(input int k);
    logic [31:0] a;
    a = DATA_BASE + 32'(4 * k);
    return ~{a[15:0], a[31:16]};
  endfunction

  function automatic logic [4:0] pick_rd();
    logic [31:0] r;
    r = take_bits(3);
    return (r[2:0] == 3'd0) ? 5'd1 : {2'b00, r[2:0]};
  endfunction

  function automatic logic [4:0] pick_rs();
    logic [31:0] r;
    r = take_bits(3);
    return {2'b00, r[2:0]};
  endfunction

  // reference ALU straight from the ISA definitions
  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b,
                                          input logic is_reg);
    case (f3)
      3'd0:    return (alt && is_reg) ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return {31'd0, $signed(a) < $signed(b)};
      3'd3:    return {31'd0, a < b};
      3'd4:    return a ^ b;
      3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  // ==========================================================================
  // program generator
  // ==========================================================================

  task automatic build_program();
    logic [31:0] r;
    logic [31:0] inst;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [11:0] imm;
    logic [12:0] boff;
    logic [20:0] joff;
    int          off;
    for (int i = 0; i < PROG_WORDS - 1; i++) begin
      r    = take_bits(4);
      rd   = pick_rd();
      rs1  = pick_rs();
      rs2  = pick_rs();
      f3   = 3'(take_bits(3));
      off  = 1 + int'(take_bits(2));
      if (off > PROG_WORDS - 1 - i) off = PROG_WORDS - 1 - i;
      boff = 13'(off * 4);
      joff = 21'(off * 4);
      case (r[3:0])
        4'd0, 4'd1, 4'd2, 4'd3, 4'd4, 4'd5: begin
          r    = take_bits(1);
          inst = {(r[0] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'b0100000 : 7'b0,
                  rs2, rs1, f3, rd, OPC_OP};
        end
        4'd6, 4'd7, 4'd8: begin
          r   = take_bits(12);
          imm = r[11:0];
          // shifts take a 5-bit amount and bit 10 picks arithmetic
          if (f3 == 3'd1) imm = {7'b0, r[4:0]};
          if (f3 == 3'd5) imm = {1'b0, r[5], 5'b0, r[4:0]};
          inst = {imm, rs1, f3, rd, OPC_OP_IMM};
        end
        4'd9: begin
          r    = take_bits(21);
          inst = {r[19:0], rd, r[20] ? OPC_LUI : OPC_AUIPC};
        end
        4'd10: begin
          r    = take_bits(4);
          imm  = 12'(DATA_BASE + {r[3:0], 2'b00});
          inst = {imm, 5'd0, 3'b010, rd, OPC_LOAD};
        end
        4'd11: begin
          r    = take_bits(4);
          imm  = 12'(DATA_BASE + {r[3:0], 2'b00});
          inst = {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], OPC_STORE};
        end
        4'd12, 4'd13: begin
          if (f3 == 3'd2) f3 = 3'd0;
          if (f3 == 3'd3) f3 = 3'd1;
          inst = {boff[12], boff[10:5], rs2, rs1, f3, boff[4:1], boff[11], OPC_BRANCH};
        end
        4'd14: begin
          rd   = pick_rs();
          inst = {joff[20], joff[10:1], joff[11], joff[19:12], rd, OPC_JAL};
        end
        default: begin
          imm  = 12'((i + off) * 4);
          inst = {imm, 5'd0, 3'b000, rd, OPC_JALR};
        end
      endcase
      irom[i] = inst;
    end
    // jal x0 to itself parks the core
    irom[PROG_WORDS-1] = {20'd0, 5'd0, OPC_JAL};
  endtask

  // ==========================================================================
  // ISA model
  // ==========================================================================

  task automatic run_model();
    logic [31:0] x [32];
    logic [31:0] mdm [16];
    logic [31:0] pc;
    logic [31:0] inst;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] nxt;
    logic [31:0] wval;
    logic [31:0] ea;
    logic        wen;
    logic        tk;
    logic [4:0]  rd;
    logic [2:0]  f3;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_j;
    int          steps;
    for (int k = 0; k < 32; k++) x[k] = '0;
    for (int k = 0; k < 16; k++) mdm[k] = fill_word(k);
    pc    = `CORE_RESET_PC;
    steps = 0;
    while (pc != LOOP_PC) begin
      if (steps > 4 * PROG_WORDS) abort_run("model did not reach the self-loop");
      steps++;
      inst  = irom[pc[7:2]];
      rd    = inst[11:7];
      f3    = inst[14:12];
      a     = x[inst[19:15]];
      b     = x[inst[24:20]];
      imm_i = {{20{inst[31]}}, inst[31:20]};
      imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
      imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
      imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
      nxt   = pc + 32'd4;
      wen   = 1'b1;
      wval  = '0;
      case (inst[6:0])
        OPC_OP:     wval = alu_ref(f3, inst[30], a, b, 1'b1);
        OPC_OP_IMM: wval = alu_ref(f3, inst[30], a, imm_i, 1'b0);
        OPC_LUI:    wval = {inst[31:12], 12'b0};
        OPC_AUIPC:  wval = pc + {inst[31:12], 12'b0};
        OPC_LOAD: begin
          ea   = a + imm_i;
          wval = mdm[ea[5:2]];
        end
        OPC_STORE: begin
          wen = 1'b0;
          ea  = a + imm_s;
          mdm[ea[5:2]] = b;
          exp_sa_q.push_back(ea);
          exp_sd_q.push_back(b);
        end
        OPC_BRANCH: begin
          wen = 1'b0;
          case (f3)
            3'd0:    tk = (a == b);
            3'd1:    tk = (a != b);
            3'd4:    tk = ($signed(a) < $signed(b));
            3'd5:    tk = ($signed(a) >= $signed(b));
            3'd6:    tk = (a < b);
            default: tk = (a >= b);
          endcase
          if (tk) nxt = pc + imm_b;
        end
        OPC_JAL: begin
          wval = pc + 32'd4;
          nxt  = pc + imm_j;
        end
        default: begin
          wval = pc + 32'd4;
          nxt  = (a + imm_i) & ~32'd1;
        end
      endcase
      if (wen && rd != 5'd0) begin
        x[rd] = wval;
        exp_rd_q.push_back(rd);
        exp_wd_q.push_back(wval);
      end
      pc = nxt;
    end
  endtask

  // ==========================================================================
  // checker sampled mid-cycle
  // ==========================================================================

  always @(negedge clk) begin
    if (!rst_n_i) begin
      if (wb_valid || dmem_we) abort_run("trace or store activity during reset");
    end else begin
      if (!fetch_checked) begin
        check_eq("first fetch address", imem_addr, `CORE_RESET_PC);
        fetch_checked = 1'b1;
      end
      if (imem_addr == LOOP_PC) loop_seen = 1'b1;
      if (wb_valid) begin
        if (exp_rd_q.size() == 0) abort_run("register write beyond the expected stream");
        check_eq("write-back rd", 32'(wb_rd), 32'(exp_rd_q.pop_front()));
        check_eq("write-back data", wb_data, exp_wd_q.pop_front());
      end
      if (dmem_we) begin
        if (exp_sa_q.size() == 0) abort_run("store beyond the expected stream");
        check_eq("store address", dmem_addr, exp_sa_q.pop_front());
        check_eq("store data", dmem_wdata, exp_sd_q.pop_front());
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT) abort_run("timeout waiting for the program to finish");
  end

  initial begin
    rst_n_i       = 1'b0;
    cycles        = 0;
    loop_seen     = 1'b0;
    fetch_checked = 1'b0;
    lfsr          = 32'he8df_ec04;
    for (int k = 0; k < 16; k++) dram[k] <= fill_word(k);
    build_program();
    run_model();
    repeat (8) @(posedge clk);
    rst_n_i <= 1'b1;
    while (!(loop_seen && exp_rd_q.size() == 0 && exp_sa_q.size() == 0)) begin
      @(posedge clk);
    end
    // the parked core must stay quiet
    repeat (16) @(posedge clk);
    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+hw
hw/core_pkg.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/reg_file.sv
hw/execute_stage.sv
hw/memory_stage.sv
hw/hazard_unit.sv
hw/core_top.sv
dv/core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the core testbench with Verilator and runs it from the project root

set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f sim.f --top-module core_tb -o core_tb_sim
status=$?
if [ $status -ne 0 ]; then
  echo "build failed with status $status"
  exit 1
fi

./obj_dir/core_tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Verification passed" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1
